/* Bender.yml */
package:
  name: rv32i_cpu

export_include_dirs:
  - .

sources:
  - cpu_pkg.sv
  - register_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - result_stage.sv
  - cpu.sv
  - target: test
    files:
      - tb_cpu.sv

/* cpu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu (
  input  logic        clk,
  input  logic        reset,
  input  logic        imem_we,
  input  logic [5:0]  imem_addr,
  input  logic [31:0] imem_wdata,
  output logic        is_halted,
  output logic [31:0] print_reg [0:31]
);
  import cpu_pkg::*;

  localparam int          IMEM_AW = $clog2(`CPU_IMEM_WORDS);
  localparam logic [31:0] NOP     = {12'd0, 5'd0, 3'b000, 5'd0, OP_IMM}; // addi x0, x0, 0

  logic [31:0]  pc;
  logic [31:0]  imem [`CPU_IMEM_WORDS];
  logic [6:0]   prog_end;  // one past last boot word
  logic [31:0]  inst;
  logic         pc_stall;
  logic         halted_q;

  logic [4:0]   rs1;
  logic [4:0]   rs2;
  logic [31:0]  rf_rs1_data;
  logic [31:0]  rf_rs2_data;
  logic [31:0]  d_rs1_data;
  logic [31:0]  d_rs2_data;
  logic [4:0]   d_rd;
  logic [31:0]  d_imm;
  alu_op_e      d_alu_op;
  logic         d_alu_src;
  logic         d_mem_read;
  logic         d_mem_write;
  logic         d_mem_to_reg;
  logic         d_reg_write;
  logic         d_halt;

  logic [4:0]   ex_rd;
  logic         ex_reg_write;
  logic         ex_mem_read;
  logic [31:0]  ex_result;
  logic [31:0]  ex_store_data;
  logic         ex_mem_write;
  logic         ex_mem_to_reg;
  logic         ex_halt;

  logic [4:0]   mem_rd;
  logic         mem_reg_write;
  logic [31:0]  mem_result;
  logic [4:0]   wb_rd;
  logic         wb_reg_write;
  logic [31:0]  wb_data;
  logic         wb_halt;

  // boot port, live only in reset
  always_ff @(posedge clk) begin
    if (reset && imem_we) begin
      imem[imem_addr] <= imem_wdata;
      prog_end        <= {1'b0, imem_addr} + 7'd1; // words load in order
    end
  end

  assign inst = (pc[31:2] < 30'(prog_end)) ? imem[pc[IMEM_AW+1:2]] : NOP;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= 32'd0;
    end else if (!pc_stall && !is_halted) begin
      pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      halted_q <= 1'b0;
    end else if (wb_halt) begin
      halted_q <= 1'b1; // sticky until reset
    end
  end

  assign is_halted = halted_q | wb_halt; // rises with ecall in writeback

  // younger instructions never commit after the halt
  register_file u_rf (
    .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(wb_rd), .wdata(wb_data),
    .we(wb_reg_write && !is_halted), .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data),
    .print_reg(print_reg)
  );

  decode_stage u_decode (
    .clk(clk), .reset(reset), .inst(inst), .rf_rs1_data(rf_rs1_data),
    .rf_rs2_data(rf_rs2_data), .ex_rd(ex_rd), .ex_reg_write(ex_reg_write),
    .ex_mem_read(ex_mem_read), .ex_result(ex_result), .mem_rd(mem_rd),
    .mem_reg_write(mem_reg_write), .mem_result(mem_result), .rs1(rs1), .rs2(rs2),
    .d_rs1_data(d_rs1_data), .d_rs2_data(d_rs2_data), .rd(d_rd), .imm(d_imm),
    .alu_op(d_alu_op), .alu_src(d_alu_src), .mem_read(d_mem_read),
    .mem_write(d_mem_write), .mem_to_reg(d_mem_to_reg), .reg_write(d_reg_write),
    .halt(d_halt), .stall(pc_stall)
  );

  execute_stage u_execute (
    .clk(clk), .reset(reset), .id_rs1(rs1), .id_rs2(rs2), .id_rs1_data(d_rs1_data),
    .id_rs2_data(d_rs2_data), .id_rd(d_rd), .id_imm(d_imm), .id_alu_op(d_alu_op),
    .id_alu_src(d_alu_src), .id_mem_read(d_mem_read), .id_mem_write(d_mem_write),
    .id_mem_to_reg(d_mem_to_reg), .id_reg_write(d_reg_write), .id_halt(d_halt),
    .bubble(pc_stall), .mem_rd(mem_rd), .mem_reg_write(mem_reg_write),
    .mem_result(mem_result), .wb_rd(wb_rd), .wb_reg_write(wb_reg_write),
    .wb_data(wb_data), .ex_rd(ex_rd), .ex_reg_write(ex_reg_write),
    .ex_mem_read(ex_mem_read), .ex_result(ex_result), .ex_store_data(ex_store_data),
    .ex_mem_write(ex_mem_write), .ex_mem_to_reg(ex_mem_to_reg), .ex_halt(ex_halt)
  );

  result_stage u_result (
    .clk(clk), .reset(reset), .ex_rd(ex_rd), .ex_reg_write(ex_reg_write),
    .ex_result(ex_result), .ex_store_data(ex_store_data), .ex_mem_read(ex_mem_read),
    .ex_mem_write(ex_mem_write), .ex_mem_to_reg(ex_mem_to_reg), .ex_halt(ex_halt),
    .mem_rd(mem_rd), .mem_reg_write(mem_reg_write), .mem_result(mem_result),
    .wb_rd(wb_rd), .wb_reg_write(wb_reg_write), .wb_data(wb_data), .wb_halt(wb_halt)
  );

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OP     = 7'b0110011, // add sub and or xor slt
    OP_IMM = 7'b0010011, // addi andi ori
    LOAD   = 7'b0000011, // lw only
    STORE  = 7'b0100011, // sw only
    SYSTEM = 7'b1110011  // ecall
  } opcode_e;

  // alu functions, resolved in decode
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5 // signed compare
  } alu_op_e;

  // operand source in execute
  typedef enum logic [1:0] {
    FWD_NONE = 2'd0, // id/ex register value
    FWD_MEM  = 2'd1, // result of the memory stage
    FWD_WB   = 2'd2  // writeback data
  } fwd_sel_e;

endpackage

/* cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// memory sizes in 32-bit words
`define CPU_IMEM_WORDS 64 // instruction memory depth
`define CPU_DMEM_WORDS 64 // data memory depth

// ecall halts only when x17 holds this value
`define CPU_HALT_CODE 10

`endif

/* decode_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic [31:0]       inst,
  input  logic [31:0]       rf_rs1_data,
  input  logic [31:0]       rf_rs2_data,
  input  logic [4:0]        ex_rd,
  input  logic              ex_reg_write,
  input  logic              ex_mem_read,
  input  logic [31:0]       ex_result,
  input  logic [4:0]        mem_rd,
  input  logic              mem_reg_write,
  input  logic [31:0]       mem_result,
  output logic [4:0]        rs1,
  output logic [4:0]        rs2,
  output logic [31:0]       d_rs1_data,
  output logic [31:0]       d_rs2_data,
  output logic [4:0]        rd,
  output logic [31:0]       imm,
  output cpu_pkg::alu_op_e  alu_op,
  output logic              alu_src,
  output logic              mem_read,
  output logic              mem_write,
  output logic              mem_to_reg,
  output logic              reg_write,
  output logic              halt,
  output logic              stall
);
  import cpu_pkg::*;

  localparam logic [4:0] X17 = 5'd17; // ecall argument register

  logic [31:0] inst_q;   // if/id register
  opcode_e     opcode;
  logic [2:0]  funct3;
  logic        is_ecall;
  logic        uses_rs1;
  logic        uses_rs2;
  logic [31:0] x17_val;  // x17 as seen by ecall

  always_ff @(posedge clk) begin
    if (reset) begin
      inst_q <= 32'd0; // decodes as no-op
    end else if (!stall) begin
      inst_q <= inst; // frozen on load-use
    end
  end

  assign opcode = opcode_e'(inst_q[6:0]);
  assign funct3 = inst_q[14:12];
  assign rd     = inst_q[11:7];
  assign rs1    = is_ecall ? X17 : inst_q[19:15]; // ecall reads x17
  assign rs2    = inst_q[24:20];

  always_comb begin
    alu_op     = ALU_ADD;
    alu_src    = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    mem_to_reg = 1'b0;
    reg_write  = 1'b0;
    is_ecall   = 1'b0;
    uses_rs1   = 1'b0;
    uses_rs2   = 1'b0;
    imm        = {{20{inst_q[31]}}, inst_q[31:20]}; // i-type
    case (opcode)
      OP: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        reg_write = 1'b1;
        case (funct3)
          3'b000:  alu_op = inst_q[30] ? ALU_SUB : ALU_ADD;
          3'b111:  alu_op = ALU_AND;
          3'b110:  alu_op = ALU_OR;
          3'b100:  alu_op = ALU_XOR;
          3'b010:  alu_op = ALU_SLT;
          default: reg_write = 1'b0; // unsupported funct3
        endcase
      end
      OP_IMM: begin
        uses_rs1  = 1'b1;
        alu_src   = 1'b1;
        reg_write = 1'b1;
        case (funct3)
          3'b000:  alu_op = ALU_ADD;
          3'b111:  alu_op = ALU_AND;
          3'b110:  alu_op = ALU_OR;
          default: reg_write = 1'b0;
        endcase
      end
      LOAD: begin
        uses_rs1   = 1'b1;
        alu_src    = 1'b1;
        mem_read   = (funct3 == 3'b010); // lw
        mem_to_reg = mem_read;
        reg_write  = mem_read;
      end
      STORE: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        alu_src   = 1'b1;
        mem_write = (funct3 == 3'b010); // sw
        imm       = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]}; // s-type
      end
      SYSTEM: begin
        is_ecall = (inst_q[31:7] == 25'd0);
        uses_rs1 = is_ecall; // reads x17
      end
      default: ; // anything else is a no-op
    endcase
  end

  // load in execute feeding a source used here
  assign stall = ex_mem_read && (ex_rd != 5'd0) &&
                 ((uses_rs1 && ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));

  // x17 priority: execute, memory, then register file
  always_comb begin
    if (ex_reg_write && ex_rd == X17) begin
      x17_val = ex_result;
    end else if (mem_reg_write && mem_rd == X17) begin
      x17_val = mem_result;
    end else begin
      x17_val = rf_rs1_data; // rs1 is x17 for ecall
    end
  end

  assign halt       = is_ecall && (x17_val == 32'(`CPU_HALT_CODE));
  assign d_rs1_data = rf_rs1_data;
  assign d_rs2_data = rf_rs2_data;

  // the bubble clears the load, so the retry proceeds
  a_stall_single: assert property (@(posedge clk) disable iff (reset) stall |=> !stall);

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic             clk,
  input  logic             reset,
  input  logic [4:0]       id_rs1,
  input  logic [4:0]       id_rs2,
  input  logic [31:0]      id_rs1_data,
  input  logic [31:0]      id_rs2_data,
  input  logic [4:0]       id_rd,
  input  logic [31:0]      id_imm,
  input  cpu_pkg::alu_op_e id_alu_op,
  input  logic             id_alu_src,
  input  logic             id_mem_read,
  input  logic             id_mem_write,
  input  logic             id_mem_to_reg,
  input  logic             id_reg_write,
  input  logic             id_halt,
  input  logic             bubble,
  input  logic [4:0]       mem_rd,
  input  logic             mem_reg_write,
  input  logic [31:0]      mem_result,
  input  logic [4:0]       wb_rd,
  input  logic             wb_reg_write,
  input  logic [31:0]      wb_data,
  output logic [4:0]       ex_rd,
  output logic             ex_reg_write,
  output logic             ex_mem_read,
  output logic [31:0]      ex_result,
  output logic [31:0]      ex_store_data,
  output logic             ex_mem_write,
  output logic             ex_mem_to_reg,
  output logic             ex_halt
);
  import cpu_pkg::*;

  logic [4:0]  rs1_q;
  logic [4:0]  rs2_q;
  logic [31:0] rs1_data_q;
  logic [31:0] rs2_data_q;
  logic [31:0] imm_q;
  alu_op_e     alu_op_q;
  logic        alu_src_q;
  fwd_sel_e    fwd_a;
  fwd_sel_e    fwd_b;
  logic [31:0] op_a;
  logic [31:0] op_b_reg; // forwarded rs2, also store data
  logic [31:0] op_b;

  function automatic fwd_sel_e pick_fwd(input logic [4:0] src, input logic [4:0] m_rd,
                                        input logic m_we, input logic [4:0] w_rd,
                                        input logic w_we);
    if (m_we && m_rd != 5'd0 && m_rd == src) begin
      return FWD_MEM; // newest value wins
    end else if (w_we && w_rd != 5'd0 && w_rd == src) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  // id/ex control, cleared by reset or a bubble
  always_ff @(posedge clk) begin
    if (reset || bubble) begin
      alu_op_q      <= ALU_ADD;
      alu_src_q     <= 1'b0;
      ex_mem_read   <= 1'b0;
      ex_mem_write  <= 1'b0;
      ex_mem_to_reg <= 1'b0;
      ex_reg_write  <= 1'b0;
      ex_halt       <= 1'b0;
    end else begin
      alu_op_q      <= id_alu_op;
      alu_src_q     <= id_alu_src;
      ex_mem_read   <= id_mem_read;
      ex_mem_write  <= id_mem_write;
      ex_mem_to_reg <= id_mem_to_reg;
      ex_reg_write  <= id_reg_write;
      ex_halt       <= id_halt;
    end
  end

  // id/ex payload
  always_ff @(posedge clk) begin
    rs1_q      <= id_rs1;
    rs2_q      <= id_rs2;
    rs1_data_q <= id_rs1_data;
    rs2_data_q <= id_rs2_data;
    imm_q      <= id_imm;
    ex_rd      <= id_rd;
  end

  assign fwd_a = pick_fwd(rs1_q, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
  assign fwd_b = pick_fwd(rs2_q, mem_rd, mem_reg_write, wb_rd, wb_reg_write);

  always_comb begin
    case (fwd_a)
      FWD_MEM: op_a = mem_result;
      FWD_WB:  op_a = wb_data;
      default: op_a = rs1_data_q;
    endcase
    case (fwd_b)
      FWD_MEM: op_b_reg = mem_result;
      FWD_WB:  op_b_reg = wb_data;
      default: op_b_reg = rs2_data_q;
    endcase
  end

  assign op_b          = alu_src_q ? imm_q : op_b_reg;
  assign ex_store_data = op_b_reg;

  always_comb begin
    case (alu_op_q)
      ALU_SUB: ex_result = op_a - op_b;
      ALU_AND: ex_result = op_a & op_b;
      ALU_OR:  ex_result = op_a | op_b;
      ALU_XOR: ex_result = op_a ^ op_b;
      ALU_SLT: ex_result = {31'd0, $signed(op_a) < $signed(op_b)};
      default: ex_result = op_a + op_b; // add, address calc
    endcase
  end

  // a selected stage must be one that writes the register file
  a_fwd_live: assert property (@(posedge clk) disable iff (reset)
    ((fwd_a == FWD_MEM || fwd_b == FWD_MEM) |-> mem_reg_write) and
    ((fwd_a == FWD_WB || fwd_b == FWD_WB) |-> wb_reg_write));

endmodule

/* project.f */
+incdir+.
cpu_pkg.sv
register_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
cpu.sv
tb_cpu.sv

/* register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic [31:0] wdata,
  input  logic        we,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  output logic [31:0] print_reg [0:31]
);

  logic [31:0] regs [0:31];
  logic        wr_live; // a real write this cycle

  assign wr_live = we && (rd != 5'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wr_live) begin
      regs[rd] <= wdata; // x0 never written
    end
  end

  // write lands in the first half of the cycle
  assign rs1_data = (wr_live && rd == rs1) ? wdata : regs[rs1];
  assign rs2_data = (wr_live && rd == rs2) ? wdata : regs[rs2];

  always_comb begin
    for (int i = 0; i < 32; i++) begin
      print_reg[i] = (wr_live && rd == 5'(i)) ? wdata : regs[i];
    end
  end

  // x0 stays zero in the dump, bypass included
  a_x0_zero: assert property (@(posedge clk) disable iff (reset) print_reg[0] == 32'd0);

endmodule

/* result_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module result_stage (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  ex_rd,
  input  logic        ex_reg_write,
  input  logic [31:0] ex_result,
  input  logic [31:0] ex_store_data,
  input  logic        ex_mem_read,
  input  logic        ex_mem_write,
  input  logic        ex_mem_to_reg,
  input  logic        ex_halt,
  output logic [4:0]  mem_rd,
  output logic        mem_reg_write,
  output logic [31:0] mem_result,
  output logic [4:0]  wb_rd,
  output logic        wb_reg_write,
  output logic [31:0] wb_data,
  output logic        wb_halt
);

  localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

  logic [31:0]        mem_alu_q;    // address or alu value
  logic [31:0]        mem_store_q;
  logic               mem_read_q;
  logic               mem_write_q;
  logic               mem_to_reg_q;
  logic               mem_halt_q;
  logic [31:0]        dmem [`CPU_DMEM_WORDS];
  logic [DMEM_AW-1:0] dmem_idx;     // word index
  logic [31:0]        load_data;
  logic [31:0]        wb_alu_q;
  logic [31:0]        wb_load_q;
  logic               wb_to_reg_q;

  // ex/mem register
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_reg_write <= 1'b0;
      mem_read_q    <= 1'b0;
      mem_write_q   <= 1'b0;
      mem_to_reg_q  <= 1'b0;
      mem_halt_q    <= 1'b0;
    end else begin
      mem_reg_write <= ex_reg_write;
      mem_read_q    <= ex_mem_read;
      mem_write_q   <= ex_mem_write;
      mem_to_reg_q  <= ex_mem_to_reg;
      mem_halt_q    <= ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    mem_rd      <= ex_rd;
    mem_alu_q   <= ex_result;
    mem_store_q <= ex_store_data;
  end

  assign dmem_idx  = mem_alu_q[DMEM_AW+1:2]; // byte address / 4
  assign load_data = dmem[dmem_idx];         // async read

  always_ff @(posedge clk) begin
    if (mem_write_q) begin
      dmem[dmem_idx] <= mem_store_q;
    end
  end

  assign mem_result = mem_read_q ? load_data : mem_alu_q; // seen by forwarding

  // mem/wb register
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
      wb_to_reg_q  <= 1'b0;
      wb_halt      <= 1'b0;
    end else begin
      wb_reg_write <= mem_reg_write;
      wb_to_reg_q  <= mem_to_reg_q;
      wb_halt      <= mem_halt_q;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd     <= mem_rd;
    wb_alu_q  <= mem_alu_q;
    wb_load_q <= load_data;
  end

  assign wb_data = wb_to_reg_q ? wb_load_q : wb_alu_q;

  // decode never asks for both
  a_rw_excl: assert property (@(posedge clk) disable iff (reset)
    !(mem_read_q && mem_write_q));

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu;
  import cpu_pkg::*;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [6:0] F7_SUB = 7'h20;

  logic        clk;
  logic        reset;
  logic        imem_we;
  logic [5:0]  imem_addr;
  logic [31:0] imem_wdata;
  logic        is_halted;
  logic [31:0] print_reg [0:31];

  logic [31:0] prog [$];        // program under test
  logic [31:0] exp_regs [0:31]; // sequential model state
  logic [31:0] mdata [int];     // model data memory, keyed by byte address
  logic [31:0] rng;             // xorshift state
  int          passed;
  int          failed;

  cpu u_dut (
    .clk(clk), .reset(reset), .imem_we(imem_we), .imem_addr(imem_addr),
    .imem_wdata(imem_wdata), .is_halted(is_halted), .print_reg(print_reg)
  );

  always #10 clk = ~clk; // 20 ns period

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] rtype(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] itype(opcode_e op, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op}; // also used for lw
  endfunction

  function automatic logic [31:0] stype(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE}; // sw
  endfunction

  function automatic logic [31:0] ecall_word();
    return {25'd0, SYSTEM};
  endfunction

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic emit_halt();
    emit(itype(OP_IMM, F3_ADD, 5'd17, 5'd0, 12'(`CPU_HALT_CODE)));
    emit(ecall_word()); // x17 forwarded straight from execute
  endtask

  // sequential reference, one instruction per step
  task automatic run_model(output bit halted, output int halt_cycle);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] res;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        wr;
    logic [4:0]  ld_rd;  // rd of a lw one step back
    logic [4:0]  src1;
    logic [4:0]  src2;
    int          stalls;
    int          idx;
    halted = 1'b0;
    idx    = 0;
    stalls = 0;
    ld_rd  = 5'd0;
    mdata.delete();
    for (int i = 0; i < 32; i++) begin
      exp_regs[i] = 32'd0;
    end
    for (int step = 0; step < 1000 && !halted; step++) begin
      w     = (idx < prog.size()) ? prog[idx] : {25'd0, OP_IMM}; // past the end is a nop
      rd    = w[11:7];
      f3    = w[14:12];
      a     = exp_regs[w[19:15]];
      b     = exp_regs[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      wr    = 1'b0;
      res   = 32'd0;
      src1  = (w[6:0] == SYSTEM) ? 5'd17 : w[19:15]; // ecall reads x17
      src2  = (w[6:0] == OP || w[6:0] == STORE) ? w[24:20] : 5'd0;
      if (ld_rd != 5'd0 && (ld_rd == src1 || ld_rd == src2)) begin
        stalls++; // one bubble after a load
      end
      case (w[6:0])
        OP: begin
          wr = 1'b1;
          case (f3)
            F3_ADD: res = w[30] ? a - b : a + b;
            F3_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR: res = a ^ b;
            F3_OR:  res = a | b;
            F3_AND: res = a & b;
            default: wr = 1'b0;
          endcase
        end
        OP_IMM: begin
          wr = 1'b1;
          case (f3)
            F3_ADD: res = a + imm_i;
            F3_OR:  res = a | imm_i;
            F3_AND: res = a & imm_i;
            default: wr = 1'b0;
          endcase
        end
        LOAD: begin
          wr  = 1'b1;
          res = mdata[int'(a + imm_i)];
        end
        STORE:  mdata[int'(a + imm_s)] = b;
        SYSTEM: halted = (exp_regs[17] == 32'(`CPU_HALT_CODE));
        default: ;
      endcase
      if (wr && rd != 5'd0) begin
        exp_regs[rd] = res;
      end
      ld_rd = (w[6:0] == LOAD && f3 == 3'b010) ? rd : 5'd0;
      idx++;
    end
    halt_cycle = idx - 1 + stalls + 4; // ecall fetch to writeback
  endtask

  // boot the program while reset is high, at least 4 cycles
  task automatic boot();
    int n;
    n = (prog.size() > 4) ? prog.size() : 4;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      reset      <= 1'b1;
      imem_we    <= (i < prog.size());
      imem_addr  <= 6'(i);
      imem_wdata <= (i < prog.size()) ? prog[i] : 32'd0;
    end
    @(posedge clk);
    imem_we <= 1'b0;
    reset   <= 1'b0;
  endtask

  task automatic wait_halt(output bit seen, output int cycles);
    seen   = 1'b0;
    cycles = 0;
    for (int c = 0; c < 500 && !seen; c++) begin
      @(negedge clk); // outputs settled
      seen   = is_halted;
      cycles = c;
    end
  endtask

  task automatic compare_regs(inout int errs);
    for (int i = 0; i < 32; i++) begin
      assert (print_reg[i] === exp_regs[i]) else begin
        $display("ERR print_reg[%0d] expected 0x%08h actual 0x%08h", i, exp_regs[i],
                 print_reg[i]);
        errs++;
      end
    end
  endtask

  task automatic check_sticky(inout int errs);
    repeat (3) begin
      @(negedge clk);
      assert (is_halted === 1'b1) else begin
        $display("is_halted dropped again after the core halted");
        errs++;
      end
    end
  endtask

  task automatic run_test(input string name);
    bit model_ok;
    bit seen;
    int errs;
    int exp_cycle;
    int cycles;
    errs = 0;
    run_model(model_ok, exp_cycle);
    if (!model_ok) begin
      $display("%s: the program never reaches a halting ecall in the model", name);
      errs++;
    end
    boot();
    wait_halt(seen, cycles);
    if (!seen) begin
      $display("%s: the core never halted within 500 cycles", name);
      errs++;
    end else begin
      assert (cycles == exp_cycle) else begin
        $display("ERR is_halted expected in cycle 0x%0h actual cycle 0x%0h", exp_cycle,
                 cycles);
        errs++;
      end
      compare_regs(errs);
      check_sticky(errs);
      compare_regs(errs); // nothing younger than the ecall commits
    end
    if (errs == 0) begin
      passed++;
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: failed with %0d errors", name, errs);
    end
  endtask

  task automatic build_independent();
    prog.delete();
    for (int i = 1; i <= 6; i++) begin
      emit(itype(OP_IMM, F3_ADD, 5'(i), 5'd0, 12'(xorshift())));
    end
    repeat (3) emit(itype(OP_IMM, F3_ADD, 5'd0, 5'd0, 12'd0)); // spacing, no hazards
    emit(rtype(7'd0, F3_ADD, 5'd10, 5'd1, 5'd2));
    emit(rtype(F7_SUB, F3_ADD, 5'd11, 5'd3, 5'd4));
    emit(rtype(7'd0, F3_AND, 5'd12, 5'd5, 5'd6));
    emit(rtype(7'd0, F3_OR, 5'd13, 5'd1, 5'd6));
    emit(rtype(7'd0, F3_XOR, 5'd14, 5'd2, 5'd5));
    emit(rtype(7'd0, F3_SLT, 5'd15, 5'd3, 5'd1));
    emit_halt();
  endtask

  task automatic build_forwarding();
    prog.delete();
    emit(itype(OP_IMM, F3_ADD, 5'd1, 5'd0, 12'(xorshift())));
    emit(itype(OP_IMM, F3_ADD, 5'd2, 5'd0, 12'(xorshift())));
    emit(rtype(7'd0, F3_ADD, 5'd3, 5'd1, 5'd2));   // x2 from mem, x1 from wb
    emit(rtype(F7_SUB, F3_ADD, 5'd4, 5'd3, 5'd1));
    emit(rtype(7'd0, F3_XOR, 5'd5, 5'd4, 5'd3));   // mem and wb together
    emit(rtype(7'd0, F3_AND, 5'd6, 5'd5, 5'd2));
    emit(rtype(7'd0, F3_OR, 5'd7, 5'd6, 5'd5));
    emit(rtype(7'd0, F3_SLT, 5'd8, 5'd7, 5'd1));
    emit(itype(OP_IMM, F3_AND, 5'd9, 5'd7, 12'(xorshift())));
    emit(itype(OP_IMM, F3_OR, 5'd10, 5'd9, 12'(xorshift())));
    emit(rtype(7'd0, F3_ADD, 5'd10, 5'd10, 5'd10)); // both operands from mem
    emit(rtype(7'd0, F3_SLT, 5'd11, 5'd10, 5'd4));
    emit_halt();
  endtask

  task automatic build_load_use();
    logic [31:0] r;
    logic [11:0] base;
    r    = xorshift();
    base = {4'd0, r[5:2], 4'd0}; // word aligned, inside dmem
    prog.delete();
    emit(itype(OP_IMM, F3_ADD, 5'd1, 5'd0, 12'(xorshift())));
    emit(itype(OP_IMM, F3_ADD, 5'd2, 5'd0, base));
    emit(stype(5'd1, 5'd2, 12'd4));
    emit(itype(LOAD, 3'b010, 5'd3, 5'd2, 12'd4));
    emit(rtype(7'd0, F3_ADD, 5'd4, 5'd3, 5'd0));  // load-use stall here
    emit(itype(OP_IMM, F3_ADD, 5'd7, 5'd0, 12'(`CPU_HALT_CODE)));
    emit(stype(5'd7, 5'd2, 12'd0));
    emit(itype(LOAD, 3'b010, 5'd17, 5'd2, 12'd0));
    emit(ecall_word());                            // stalls on the x17 load
  endtask

  task automatic build_ecall();
    logic [11:0] code;
    code = 12'(xorshift());
    if (code == 12'(`CPU_HALT_CODE)) begin
      code = code + 12'd1; // must not halt
    end
    prog.delete();
    emit(itype(OP_IMM, F3_ADD, 5'd17, 5'd0, code));
    emit(ecall_word());
    emit(itype(OP_IMM, F3_ADD, 5'd5, 5'd0, 12'(xorshift())));
    emit(rtype(7'd0, F3_ADD, 5'd6, 5'd5, 5'd17));
    emit_halt();
    emit(itype(OP_IMM, F3_ADD, 5'd7, 5'd0, 12'd99)); // never commits
    emit(itype(OP_IMM, F3_ADD, 5'd8, 5'd0, 12'd55));
  endtask

  task automatic build_x0();
    prog.delete();
    emit(itype(OP_IMM, F3_ADD, 5'd0, 5'd0, 12'(xorshift() | 32'd1))); // dropped write
    emit(itype(OP_IMM, F3_ADD, 5'd1, 5'd0, 12'd5)); // x0 read right after
    emit(rtype(7'd0, F3_ADD, 5'd2, 5'd0, 5'd1));
    emit(rtype(7'd0, F3_ADD, 5'd0, 5'd1, 5'd1));
    emit(rtype(F7_SUB, F3_ADD, 5'd3, 5'd0, 5'd1)); // expects -5
    emit_halt();
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    imem_we    = 1'b0;
    imem_addr  = 6'd0;
    imem_wdata = 32'd0;
    rng        = 32'd64165;
    passed     = 0;
    failed     = 0;
    build_independent();
    run_test("independent arithmetic");
    for (int r = 0; r < 3; r++) begin
      build_forwarding();
      run_test($sformatf("forwarding round %0d", r));
    end
    build_load_use();
    run_test("store, load and load-use stall");
    build_ecall();
    run_test("ecall with and without halt code");
    build_x0();
    run_test("writes to x0");
    $display("tests passed: %0d, tests failed: %0d", passed, failed);
    if (failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
